// File: compile.f
ddram_cmd_pkg.sv
ddram_csr_pkg.sv
ddram_csr.sv
ddram_scheduler.sv
ddram_datapath.sv
ddram.sv
tb_clkgen.sv
tb_sdram_model.sv
tb_ddram.sv

// File: ddram.sv
`timescale 1ns/1ns

module ddram (
	input  logic                                sys_clk,
	input  logic                                arst_n,

	// CSR port.
	input  logic [13:0]                         csr_a,
	input  logic                                csr_we,
	input  logic [31:0]                         csr_di,
	output logic [31:0]                         csr_do,

	// FML port, single 64-bit accesses.
	input  logic [ddram_cmd_pkg::FML_ADR_W-1:0] fml_adr,
	input  logic                                fml_stb,
	input  logic                                fml_we,
	output logic                                fml_ack,
	input  logic [7:0]                          fml_sel,
	input  logic [63:0]                         fml_di,
	output logic [63:0]                         fml_do,

	// SDRAM pads.
	output logic                                sdram_cke,
	output logic                                sdram_cs_n,
	output logic                                sdram_we_n,
	output logic                                sdram_cas_n,
	output logic                                sdram_ras_n,
	output logic [ddram_cmd_pkg::ROW_W-1:0]     sdram_adr,
	output logic [ddram_cmd_pkg::BANK_W-1:0]    sdram_ba,
	output logic [3:0]                          sdram_dqm,
	inout  wire  [31:0]                         sdram_dq
);

logic                             bypass;
logic                             cke;
logic [15:0]                      refresh_interval;
logic                             bypass_stb;
ddram_csr_pkg::csr_bypass_u       bypass_cmd;
logic [3:0]                       cmd;
logic [ddram_cmd_pkg::ROW_W-1:0]  adr;
logic [ddram_cmd_pkg::BANK_W-1:0] ba;
logic                             wr_start;
logic                             rd_start;
logic                             rd_done;

ddram_csr csr_i (
	.sys_clk(sys_clk), .arst_n(arst_n),
	.csr_a(csr_a), .csr_we(csr_we), .csr_di(csr_di), .csr_do(csr_do),
	.bypass(bypass), .cke(cke), .refresh_interval(refresh_interval),
	.bypass_stb(bypass_stb), .bypass_cmd(bypass_cmd)
);

ddram_scheduler scheduler_i (
	.sys_clk(sys_clk), .arst_n(arst_n),
	.bypass(bypass), .refresh_interval(refresh_interval),
	.bypass_stb(bypass_stb), .bypass_cmd(bypass_cmd),
	.fml_adr(fml_adr), .fml_stb(fml_stb), .fml_we(fml_we), .fml_ack(fml_ack),
	.cmd(cmd), .adr(adr), .ba(ba),
	.wr_start(wr_start), .rd_start(rd_start), .rd_done(rd_done)
);

ddram_datapath datapath_i (
	.sys_clk(sys_clk), .arst_n(arst_n),
	.cke_in(cke), .cmd(cmd), .adr(adr), .ba(ba),
	.wr_start(wr_start), .rd_start(rd_start),
	.fml_sel(fml_sel), .fml_di(fml_di), .fml_do(fml_do), .rd_done(rd_done),
	.sdram_cke(sdram_cke), .sdram_cs_n(sdram_cs_n), .sdram_ras_n(sdram_ras_n),
	.sdram_cas_n(sdram_cas_n), .sdram_we_n(sdram_we_n),
	.sdram_adr(sdram_adr), .sdram_ba(sdram_ba),
	.sdram_dqm(sdram_dqm), .sdram_dq(sdram_dq)
);

endmodule

// File: ddram_cmd_pkg.sv
package ddram_cmd_pkg;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pin commands, {cs_n, ras_n, cas_n, we_n}
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
localparam logic [3:0] CMD_NOP   = 4'b0111;
localparam logic [3:0] CMD_ACT   = 4'b0011;
localparam logic [3:0] CMD_READ  = 4'b0101;
localparam logic [3:0] CMD_WRITE = 4'b0100;
localparam logic [3:0] CMD_PRE   = 4'b0010;
localparam logic [3:0] CMD_REF   = 4'b0001;
localparam logic [3:0] CMD_MRS   = 4'b0000;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Device timing, in sys_clk cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
localparam int T_RCD   = 2; // ACT to READ/WRITE.
localparam int T_RP    = 2; // PRE to ACT.
localparam int T_RFC   = 8; // REF to next command.
localparam int CAS_LAT = 2; // READ to first beat.

// Wait counter loads; a state issues its command once the counter is zero.
localparam int WAIT_W = 4;
localparam logic [WAIT_W-1:0] RP_WAIT     = WAIT_W'(T_RP - 1);
localparam logic [WAIT_W-1:0] RCD_WAIT    = WAIT_W'(T_RCD - 1);
localparam logic [WAIT_W-1:0] RFC_WAIT    = WAIT_W'(T_RFC - 1);
localparam logic [WAIT_W-1:0] WR_ACK_WAIT = WAIT_W'(1);

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address fields
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
localparam int FML_ADR_W   = 26;
localparam int ROW_W       = 13;
localparam int BANK_W      = 2;
localparam int COL_W       = 9;
localparam int NBANKS      = 1 << BANK_W;
localparam int COL_LSB     = 3;  // Byte offset below is dropped.
localparam int BANK_LSB    = 11;
localparam int ROW_LSB     = 13;
localparam int PRE_ALL_BIT = 10; // A10 selects all banks on PRE.

// Scheduler FSM states.
localparam int ST_W = 3;
localparam logic [ST_W-1:0] S_IDLE   = 3'd0;
localparam logic [ST_W-1:0] S_PRE    = 3'd1;
localparam logic [ST_W-1:0] S_ACT    = 3'd2;
localparam logic [ST_W-1:0] S_ACCESS = 3'd3;
localparam logic [ST_W-1:0] S_WREAD  = 3'd4;
localparam logic [ST_W-1:0] S_RPRE   = 3'd5;
localparam logic [ST_W-1:0] S_REF    = 3'd6;

endpackage

// File: ddram_csr.sv
`timescale 1ns/1ns

module ddram_csr (
	input  logic                       sys_clk,
	input  logic                       arst_n,

	input  logic [13:0]                csr_a,
	input  logic                       csr_we,
	input  logic [31:0]                csr_di,
	output logic [31:0]                csr_do,

	output logic                       bypass,
	output logic                       cke,
	output logic [15:0]                refresh_interval,
	output logic                       bypass_stb,
	output ddram_csr_pkg::csr_bypass_u bypass_cmd
);

logic       hit;
logic [1:0] idx;
logic       wr_bypass;

assign hit       = (csr_a[13:10] == ddram_csr_pkg::CSR_PAGE);
assign idx       = csr_a[1:0];
assign wr_bypass = hit && csr_we && (idx == ddram_csr_pkg::REG_BYPASS);

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
always_ff @(posedge sys_clk or negedge arst_n) begin
	if (!arst_n) begin
		bypass           <= 1'b1; // Software owns the device after reset.
		cke              <= 1'b0;
		refresh_interval <= ddram_csr_pkg::REFRESH_RST;
		bypass_stb       <= 1'b0;
	end else begin
		bypass_stb <= wr_bypass; // One cycle after the write.
		if (hit && csr_we) begin
			case (idx)
				ddram_csr_pkg::REG_CTRL: begin
					bypass <= csr_di[ddram_csr_pkg::CTRL_BYPASS];
					cke    <= csr_di[ddram_csr_pkg::CTRL_CKE];
				end
				ddram_csr_pkg::REG_REFRESH: refresh_interval <= csr_di[15:0];
				default: ;
			endcase
		end
	end
end

// Command word is payload only.
always_ff @(posedge sys_clk) begin
	if (wr_bypass)
		bypass_cmd.raw <= csr_di;
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Readback
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
always_ff @(posedge sys_clk or negedge arst_n) begin
	if (!arst_n) begin
		csr_do <= '0;
	end else begin
		csr_do <= '0; // Misses read as zero.
		if (hit) begin
			case (idx)
				ddram_csr_pkg::REG_CTRL:    csr_do <= {30'd0, cke, bypass};
				ddram_csr_pkg::REG_BYPASS:  csr_do <= bypass_cmd.raw;
				ddram_csr_pkg::REG_REFRESH: csr_do <= {16'd0, refresh_interval};
				default: ;
			endcase
		end
	end
end

endmodule

// File: ddram_csr_pkg.sv
package ddram_csr_pkg;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CSR decoding
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
localparam logic [3:0] CSR_PAGE = 4'h0; // Compared with csr_a[13:10].

localparam logic [1:0] REG_CTRL    = 2'd0;
localparam logic [1:0] REG_BYPASS  = 2'd1;
localparam logic [1:0] REG_REFRESH = 2'd2;

// REG_CTRL bit positions.
localparam int CTRL_BYPASS = 0;
localparam int CTRL_CKE    = 1;

localparam logic [15:0] REFRESH_RST = 16'd740; // Default refresh interval.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bypass command word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Software writes it as a plain word and the scheduler
// drives the pin fields straight onto the command bus.
typedef union packed {
	logic [31:0] raw;
	struct packed {
		logic [12:0] rsvd;  // Bits 31..19, ignored.
		logic [1:0]  ba;    // Bits 18..17.
		logic [12:0] adr;   // Bits 16..4.
		logic        ras_n; // Bit 3.
		logic        cas_n; // Bit 2.
		logic        we_n;  // Bit 1.
		logic        cs_n;  // Bit 0.
	} pins;
} csr_bypass_u;

endpackage

// File: ddram_datapath.sv
`timescale 1ns/1ns

module ddram_datapath (
	input  logic                             sys_clk,
	input  logic                             arst_n,

	input  logic                             cke_in,
	input  logic [3:0]                       cmd,
	input  logic [ddram_cmd_pkg::ROW_W-1:0]  adr,
	input  logic [ddram_cmd_pkg::BANK_W-1:0] ba,
	input  logic                             wr_start,
	input  logic                             rd_start,

	input  logic [7:0]                       fml_sel,
	input  logic [63:0]                      fml_di,
	output logic [63:0]                      fml_do,
	output logic                             rd_done,

	output logic                             sdram_cke,
	output logic                             sdram_cs_n,
	output logic                             sdram_ras_n,
	output logic                             sdram_cas_n,
	output logic                             sdram_we_n,
	output logic [ddram_cmd_pkg::ROW_W-1:0]  sdram_adr,
	output logic [ddram_cmd_pkg::BANK_W-1:0] sdram_ba,
	output logic [3:0]                       sdram_dqm,
	inout  wire  [31:0]                      sdram_dq
);

logic        dq_oe;
logic        wr_beat; // Second write beat pending.
logic [31:0] dq_out;
logic [31:0] rd_hi;
// Bit i is high i+1 cycles after rd_start, aligned with the pad command.
logic [ddram_cmd_pkg::CAS_LAT+1:0] rd_pipe;

assign sdram_dq = dq_oe ? dq_out : 'z;

always_ff @(posedge sys_clk or negedge arst_n) begin
	if (!arst_n) begin
		sdram_cke <= 1'b0;
		{sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} <= ddram_cmd_pkg::CMD_NOP;
		sdram_adr <= '0;
		sdram_ba  <= '0;
		sdram_dqm <= 4'hf;
		dq_oe     <= 1'b0;
		wr_beat   <= 1'b0;
		rd_pipe   <= '0;
		rd_done   <= 1'b0;
	end else begin
		sdram_cke <= cke_in;
		{sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} <= cmd;
		sdram_adr <= adr;
		sdram_ba  <= ba;
		if (wr_start) begin
			dq_oe     <= 1'b1;
			wr_beat   <= 1'b1;
			sdram_dqm <= ~fml_sel[7:4]; // High half goes first.
		end else if (wr_beat) begin
			wr_beat   <= 1'b0;
			sdram_dqm <= ~fml_sel[3:0];
		end else begin
			dq_oe     <= 1'b0;
			sdram_dqm <= (rd_start || (|rd_pipe)) ? 4'h0 : 4'hf;
		end
		rd_pipe <= {rd_pipe[ddram_cmd_pkg::CAS_LAT:0], rd_start};
		rd_done <= rd_pipe[ddram_cmd_pkg::CAS_LAT+1];
	end
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Beat data
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
always_ff @(posedge sys_clk) begin
	if (wr_start)
		dq_out <= fml_di[63:32];
	else if (wr_beat)
		dq_out <= fml_di[31:0];
	if (rd_pipe[ddram_cmd_pkg::CAS_LAT])
		rd_hi <= sdram_dq; // First beat.
	if (rd_pipe[ddram_cmd_pkg::CAS_LAT+1])
		fml_do <= {rd_hi, sdram_dq};
end

endmodule

// File: ddram_scheduler.sv
`timescale 1ns/1ns

module ddram_scheduler (
	input  logic                                  sys_clk,
	input  logic                                  arst_n,

	input  logic                                  bypass,
	input  logic [15:0]                           refresh_interval,
	input  logic                                  bypass_stb,
	input  ddram_csr_pkg::csr_bypass_u            bypass_cmd,

	input  logic [ddram_cmd_pkg::FML_ADR_W-1:0]   fml_adr,
	input  logic                                  fml_stb,
	input  logic                                  fml_we,
	output logic                                  fml_ack,

	output logic [3:0]                            cmd,
	output logic [ddram_cmd_pkg::ROW_W-1:0]       adr,
	output logic [ddram_cmd_pkg::BANK_W-1:0]      ba,
	output logic                                  wr_start,
	output logic                                  rd_start,
	input  logic                                  rd_done
);

logic [ddram_cmd_pkg::ST_W-1:0]   state;
logic [ddram_cmd_pkg::WAIT_W-1:0] cnt;
logic                             ack_q;
logic [15:0]                      ref_cnt;
logic                             ref_due;

logic [ddram_cmd_pkg::NBANKS-1:0] bank_open;
logic [ddram_cmd_pkg::ROW_W-1:0]  open_row [ddram_cmd_pkg::NBANKS];

// Request fields, held stable by the host until fml_ack.
logic [ddram_cmd_pkg::ROW_W-1:0]  req_row;
logic [ddram_cmd_pkg::BANK_W-1:0] req_ba;
logic [ddram_cmd_pkg::COL_W-1:0]  req_col;

assign req_row = fml_adr[ddram_cmd_pkg::ROW_LSB +: ddram_cmd_pkg::ROW_W];
assign req_ba  = fml_adr[ddram_cmd_pkg::BANK_LSB +: ddram_cmd_pkg::BANK_W];
assign req_col = {fml_adr[ddram_cmd_pkg::COL_LSB +: ddram_cmd_pkg::COL_W - 1], 1'b0};

// Write ack comes from the FSM, read ack straight from the capture.
assign fml_ack = ack_q | rd_done;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Command decode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
always_comb begin
	cmd      = ddram_cmd_pkg::CMD_NOP;
	adr      = '0;
	ba       = '0;
	wr_start = 1'b0;
	rd_start = 1'b0;
	if (state == ddram_cmd_pkg::S_IDLE) begin
		if (bypass && bypass_stb) begin
			cmd = {bypass_cmd.pins.cs_n, bypass_cmd.pins.ras_n,
				bypass_cmd.pins.cas_n, bypass_cmd.pins.we_n};
			adr = bypass_cmd.pins.adr;
			ba  = bypass_cmd.pins.ba;
		end
	end else if (cnt == '0) begin
		case (state)
			ddram_cmd_pkg::S_PRE: begin
				cmd = ddram_cmd_pkg::CMD_PRE;
				ba  = req_ba;
			end
			ddram_cmd_pkg::S_ACT: begin
				cmd = ddram_cmd_pkg::CMD_ACT;
				adr = req_row;
				ba  = req_ba;
			end
			ddram_cmd_pkg::S_ACCESS: begin
				cmd = fml_we ? ddram_cmd_pkg::CMD_WRITE : ddram_cmd_pkg::CMD_READ;
				adr[ddram_cmd_pkg::COL_W-1:0] = req_col; // A10 low, no auto precharge.
				ba       = req_ba;
				wr_start = fml_we;
				rd_start = !fml_we;
			end
			ddram_cmd_pkg::S_RPRE: begin
				cmd = ddram_cmd_pkg::CMD_PRE;
				adr[ddram_cmd_pkg::PRE_ALL_BIT] = 1'b1;
			end
			ddram_cmd_pkg::S_REF: cmd = ddram_cmd_pkg::CMD_REF;
			default: ;
		endcase
	end
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sequencing FSM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
always_ff @(posedge sys_clk or negedge arst_n) begin
	if (!arst_n) begin
		state     <= ddram_cmd_pkg::S_IDLE;
		cnt       <= '0;
		ack_q     <= 1'b0;
		bank_open <= '0;
	end else begin
		ack_q <= 1'b0;
		if (cnt != '0) begin
			cnt <= cnt - 1'b1; // Timing gap, NOP on the bus.
		end else begin
			case (state)
				ddram_cmd_pkg::S_IDLE: begin
					if (bypass) begin
						state <= ddram_cmd_pkg::S_IDLE;
					end else if (ref_due) begin
						state <= ddram_cmd_pkg::S_RPRE;
					end else if (fml_stb && !ack_q) begin
						if (!bank_open[req_ba])
							state <= ddram_cmd_pkg::S_ACT;
						else if (open_row[req_ba] != req_row)
							state <= ddram_cmd_pkg::S_PRE; // Row miss.
						else
							state <= ddram_cmd_pkg::S_ACCESS;
					end
				end
				ddram_cmd_pkg::S_PRE: begin
					bank_open[req_ba] <= 1'b0;
					state             <= ddram_cmd_pkg::S_ACT;
					cnt               <= ddram_cmd_pkg::RP_WAIT;
				end
				ddram_cmd_pkg::S_ACT: begin
					bank_open[req_ba] <= 1'b1;
					state             <= ddram_cmd_pkg::S_ACCESS;
					cnt               <= ddram_cmd_pkg::RCD_WAIT;
				end
				ddram_cmd_pkg::S_ACCESS: begin
					state <= ddram_cmd_pkg::S_WREAD;
					cnt   <= fml_we ? ddram_cmd_pkg::WR_ACK_WAIT : '0;
				end
				ddram_cmd_pkg::S_WREAD: begin
					if (fml_we) begin
						ack_q <= 1'b1;
						state <= ddram_cmd_pkg::S_IDLE;
					end else if (rd_done) begin
						state <= ddram_cmd_pkg::S_IDLE;
					end
				end
				ddram_cmd_pkg::S_RPRE: begin
					bank_open <= '0;
					state     <= ddram_cmd_pkg::S_REF;
					cnt       <= ddram_cmd_pkg::RP_WAIT;
				end
				ddram_cmd_pkg::S_REF: begin
					state <= ddram_cmd_pkg::S_IDLE;
					cnt   <= ddram_cmd_pkg::RFC_WAIT;
				end
				default: state <= ddram_cmd_pkg::S_IDLE;
			endcase
		end
		if (bypass)
			bank_open <= '0; // Software may touch any bank.
	end
end

// Open row per bank, valid only where bank_open is set.
always_ff @(posedge sys_clk) begin
	if (state == ddram_cmd_pkg::S_ACT && cnt == '0)
		open_row[req_ba] <= req_row;
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Refresh timer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
always_ff @(posedge sys_clk or negedge arst_n) begin
	if (!arst_n) begin
		ref_cnt <= '0;
		ref_due <= 1'b0;
	end else if (bypass) begin
		ref_cnt <= refresh_interval; // Suspended.
		ref_due <= 1'b0;
	end else begin
		if (state == ddram_cmd_pkg::S_REF && cnt == '0)
			ref_due <= 1'b0;
		if (ref_cnt == '0) begin
			ref_cnt <= refresh_interval;
			ref_due <= 1'b1;
		end else begin
			ref_cnt <= ref_cnt - 1'b1;
		end
	end
end

endmodule

// File: tb_clkgen.sv
`timescale 1ns/1ns

module tb_clkgen (
	output logic sys_clk,
	output logic arst_n
);

initial sys_clk = 1'b0;
always #4 sys_clk = ~sys_clk; // 8 ns period.

initial begin
	arst_n = 1'b0;
	repeat (10) @(posedge sys_clk);
	#1 arst_n = 1'b1; // Released off the edge.
end

endmodule

// File: tb_ddram.sv
`timescale 1ns/1ns

module tb_ddram;

localparam int OP_CSR_WR = 0;
localparam int OP_CSR_RD = 1;
localparam int OP_BYP    = 2; // Bypass write plus pad check.
localparam int OP_FML_WR = 3;
localparam int OP_FML_RD = 4;
localparam int OP_IDLE   = 5; // Idle wait with a refresh count check.

typedef struct {
	int          op;
	logic [31:0] adr;
	logic [63:0] data;
	logic [7:0]  sel;
	logic [31:0] exp;
} step_t;

logic        sys_clk, arst_n;
logic [13:0] csr_a;
logic        csr_we;
logic [31:0] csr_di, csr_do;
logic [25:0] fml_adr;
logic        fml_stb, fml_we, fml_ack;
logic [7:0]  fml_sel;
logic [63:0] fml_di, fml_do;
logic        sdram_cke, sdram_cs_n, sdram_we_n, sdram_cas_n, sdram_ras_n;
logic [12:0] sdram_adr;
logic [1:0]  sdram_ba;
logic [3:0]  sdram_dqm;
wire  [31:0] sdram_dq;
logic        proto_err;
int          ref_count, cmd_count;
logic [3:0]  last_cmd;
logic [12:0] last_adr;
logic [1:0]  last_ba;

step_t       tbl [$];
logic [63:0] shadow [int]; // Expected memory, by 64-bit word.
logic [31:0] lfsr_state = 32'h9232_6f3b;
int          cycles;
int          limit;

tb_clkgen clkgen_i (.sys_clk(sys_clk), .arst_n(arst_n));
ddram dut_i (.*);
tb_sdram_model model_i (.*);

task automatic stop_run(input string msg);
	$display("%s", msg);
	$display("Regression failed");
	$fatal(1, "Run stopped at first error.");
endtask

always @(posedge proto_err) stop_run("SDRAM model reported a protocol violation.");

always @(posedge sys_clk) begin
	cycles++;
	if (limit > 0 && cycles > limit)
		stop_run($sformatf("Timeout after %0d cycles, the DUT stopped responding.", cycles));
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Compare tasks and stimulus helpers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
task automatic check_csr(input logic [31:0] got, input logic [31:0] exp, input string what);
	if (got !== exp)
		stop_run($sformatf("FAILED t=%0t %s: got %h expected %h", $time, what, got, exp));
endtask

task automatic check_fml(input logic [63:0] got, input logic [63:0] exp, input string what);
	if (got !== exp)
		stop_run($sformatf("FAILED t=%0t %s: got %h expected %h", $time, what, got, exp));
endtask

task automatic check_pad_cmd(input logic [18:0] got, input logic [18:0] exp);
	if (got !== exp)
		stop_run($sformatf("FAILED t=%0t bypass pad command: got %h expected %h",
			$time, got, exp));
endtask

task automatic check_count(input int got, input int lo, input int hi, input string what);
	if (got < lo || got > hi)
		stop_run($sformatf("FAILED t=%0t %s: got %0d expected %0d..%0d", $time, what, got, lo, hi));
endtask

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1.
endfunction

task automatic random_word(output logic [63:0] w);
	for (int i = 0; i < 64; i++) begin
		lfsr_state = lfsr_next(lfsr_state);
		w[i] = lfsr_state[0];
	end
endtask

function automatic logic [31:0] fml_addr(input int row, input int bank, input int col);
	return {6'd0, row[12:0], bank[1:0], col[7:0], 3'd0};
endfunction

// Pin fields from the bypass word layout; cmd is {cs_n, ras_n, cas_n, we_n}.
function automatic logic [31:0] bypass_word(input logic [3:0] c, input logic [12:0] a,
	input logic [1:0] b);
	return {13'd0, b, a, c[2], c[1], c[0], c[3]};
endfunction

task automatic add_step(input int op, input logic [31:0] adr, input logic [63:0] data,
	input logic [7:0] sel, input logic [31:0] exp);
	step_t s;
	s.op   = op;
	s.adr  = adr;
	s.data = data;
	s.sel  = sel;
	s.exp  = exp;
	tbl.push_back(s);
endtask

task automatic add_bypass(input logic [3:0] c, input logic [12:0] a, input logic [1:0] b);
	add_step(OP_BYP, 1, 64'(bypass_word(c, a, b)), 0, {13'd0, b, a, c});
endtask

task automatic csr_access(input logic [13:0] a, input logic we, input logic [31:0] d,
	output logic [31:0] q);
	csr_a  = a;
	csr_we = we;
	csr_di = d;
	@(posedge sys_clk);
	#1 csr_we = 1'b0;
	q = csr_do; // Registered readback appears one cycle after the address.
endtask

task automatic fml_access(input logic [25:0] a, input logic we, input logic [7:0] sel,
	input logic [63:0] d, output logic [63:0] q);
	fml_adr = a;
	fml_we  = we;
	fml_sel = sel;
	fml_di  = d;
	fml_stb = 1'b1;
	do begin
		@(posedge sys_clk);
		#1;
	end while (!fml_ack);
	q       = fml_do;
	fml_stb = 1'b0;
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stimulus table and main loop
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
initial begin
	logic [31:0] q32;
	logic [63:0] q64, w, merged;
	int          key, r0, c0;
	csr_a   = '0;
	csr_we  = 1'b0;
	csr_di  = '0;
	fml_adr = '0;
	fml_stb = 1'b0;
	fml_we  = 1'b0;
	fml_sel = '0;
	fml_di  = '0;
	cycles  = 0;
	limit   = 0;

	add_step(OP_CSR_RD, 0, 0, 0, 32'h1);        // Bypass 1, cke 0.
	add_step(OP_CSR_RD, 2, 0, 0, 32'd740);
	add_step(OP_CSR_RD, 14'h0402, 0, 0, 32'h0); // Other page.
	add_step(OP_CSR_WR, 2, 64'h1234, 0, 0);
	add_step(OP_CSR_RD, 2, 0, 0, 32'h1234);
	add_step(OP_CSR_WR, 2, 64'd100, 0, 0);      // Short refresh interval for the rest of the run.
	add_bypass(ddram_cmd_pkg::CMD_PRE, 13'h0400, 2'd0);
	add_bypass(ddram_cmd_pkg::CMD_MRS, 13'h0022, 2'd0);
	add_bypass(ddram_cmd_pkg::CMD_REF, 13'h0000, 2'd0);
	add_bypass(ddram_cmd_pkg::CMD_REF, 13'h0000, 2'd0);
	add_step(OP_CSR_RD, 1, 0, 0, bypass_word(ddram_cmd_pkg::CMD_REF, 0, 0));
	add_step(OP_CSR_WR, 0, 64'h2, 0, 0);        // Bypass off, cke on.
	add_step(OP_CSR_RD, 0, 0, 0, 32'h2);
	add_step(OP_FML_WR, fml_addr(1, 0, 5), 0, 8'hff, 0);
	add_step(OP_FML_WR, fml_addr(2, 0, 5), 0, 8'hff, 0);
	add_step(OP_FML_WR, fml_addr(1, 1, 0), 0, 8'hff, 0);
	add_step(OP_FML_WR, fml_addr(3, 3, 255), 0, 8'hff, 0);
	add_step(OP_FML_WR, fml_addr(1, 0, 5), 0, 8'h0f, 0); // Low bytes only.
	add_step(OP_FML_WR, fml_addr(2, 0, 5), 0, 8'h90, 0);
	for (int i = 0; i < 2; i++) begin
		add_step(OP_FML_RD, fml_addr(1, 0, 5), 0, 0, 0);
		add_step(OP_FML_RD, fml_addr(2, 0, 5), 0, 0, 0);
		add_step(OP_FML_RD, fml_addr(1, 1, 0), 0, 0, 0);
		add_step(OP_FML_RD, fml_addr(3, 3, 255), 0, 0, 0);
		if (i == 0)
			add_step(OP_IDLE, 0, 64'd1400, 0, 0);
	end

	limit = 40 * tbl.size() + 2000;

	wait (arst_n === 1'b1);
	@(posedge sys_clk);
	#1;
	foreach (tbl[i]) begin
		case (tbl[i].op)
			OP_CSR_WR: csr_access(tbl[i].adr[13:0], 1'b1, tbl[i].data[31:0], q32);
			OP_CSR_RD: begin
				csr_access(tbl[i].adr[13:0], 1'b0, 0, q32);
				check_csr(q32, tbl[i].exp, $sformatf("CSR read %h", tbl[i].adr[13:0]));
			end
			OP_BYP: begin
				c0 = cmd_count;
				csr_access(tbl[i].adr[13:0], 1'b1, tbl[i].data[31:0], q32);
				repeat (4) @(posedge sys_clk); // Strobe and pad register stages.
				#1;
				check_count(cmd_count - c0, 1, 1, "bypass commands at the pads");
				check_pad_cmd({last_ba, last_adr, last_cmd}, tbl[i].exp[18:0]);
			end
			OP_FML_WR: begin
				random_word(w);
				key    = tbl[i].adr >> 3;
				merged = shadow.exists(key) ? shadow[key] : 64'h0;
				for (int b = 0; b < 8; b++)
					if (tbl[i].sel[b])
						merged[8*b +: 8] = w[8*b +: 8];
				shadow[key] = merged;
				fml_access(tbl[i].adr[25:0], 1'b1, tbl[i].sel, w, q64);
			end
			OP_FML_RD: begin
				key = tbl[i].adr >> 3;
				fml_access(tbl[i].adr[25:0], 1'b0, 8'hff, 0, q64);
				check_fml(q64, shadow.exists(key) ? shadow[key] : 64'h0,
					$sformatf("FML read %h", tbl[i].adr[25:0]));
			end
			OP_IDLE: begin
				r0 = ref_count;
				repeat (int'(tbl[i].data)) @(posedge sys_clk);
				#1;
				check_count(ref_count - r0, int'(tbl[i].data) / 140, 1 << 30,
					"refreshes while idle");
			end
			default: stop_run("Unknown operation in the stimulus table.");
		endcase
	end
	$display("Regression passed");
	$finish;
end

endmodule

// File: tb_sdram_model.sv
`timescale 1ns/1ns

module tb_sdram_model (
	input  logic        sys_clk,
	input  logic        sdram_cke,
	input  logic        sdram_cs_n,
	input  logic        sdram_ras_n,
	input  logic        sdram_cas_n,
	input  logic        sdram_we_n,
	input  logic [12:0] sdram_adr,
	input  logic [1:0]  sdram_ba,
	input  logic [3:0]  sdram_dqm,
	inout  wire  [31:0] sdram_dq,
	output logic        proto_err,
	output int          ref_count,
	output int          cmd_count,
	output logic [3:0]  last_cmd,
	output logic [12:0] last_adr,
	output logic [1:0]  last_ba
);

logic [31:0] mem [int]; // Sparse store keyed by {bank, row, column}.
logic [3:0]  bank_open;
logic [12:0] open_row [4];
int          act_cyc [4];
int          cyc;
int          rd_step;
int          rd_key;
bit          wr_beat;
int          wr_key;
logic [31:0] dq_drv;
logic        dq_oe;
logic [3:0]  pcmd;

assign sdram_dq = dq_oe ? dq_drv : 'z;

initial begin
	proto_err = 1'b0;
	ref_count = 0;
	cmd_count = 0;
	bank_open = '0;
	cyc       = 0;
	rd_step   = 0;
	wr_beat   = 1'b0;
	dq_oe     = 1'b0;
end

task automatic protocol_error(input string msg);
	$display("SDRAM model error at %0t: %s", $time, msg);
	proto_err = 1'b1;
endtask

function automatic logic [31:0] fetch(input int key);
	return mem.exists(key) ? mem[key] : 32'h0;
endfunction

// A set dqm bit masks its byte lane.
task automatic store(input int key, input logic [31:0] d, input logic [3:0] dqm);
	logic [31:0] w;
	w = fetch(key);
	for (int i = 0; i < 4; i++)
		if (!dqm[i])
			w[8*i +: 8] = d[8*i +: 8];
	mem[key] = w;
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Command decode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
always @(posedge sys_clk) begin
	cyc++;
	case (rd_step) // Beats land CAS_LAT and CAS_LAT+1 after READ.
		1: begin
			dq_drv  <= fetch(rd_key);
			dq_oe   <= 1'b1;
			rd_step = 2;
		end
		2: begin
			dq_drv  <= fetch(rd_key + 1);
			rd_step = 3;
		end
		3: begin
			dq_oe   <= 1'b0;
			rd_step = 0;
		end
		default: ;
	endcase
	if (wr_beat) begin
		store(wr_key + 1, sdram_dq, sdram_dqm); // Second beat goes to column + 1.
		wr_beat = 1'b0;
	end
	pcmd = {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n};
	if (!sdram_cs_n && pcmd != ddram_cmd_pkg::CMD_NOP) begin
		cmd_count++;
		last_cmd = pcmd;
		last_adr = sdram_adr;
		last_ba  = sdram_ba;
		case (pcmd)
			ddram_cmd_pkg::CMD_ACT: begin
				if (!sdram_cke)
					protocol_error("activate while the clock enable is low");
				if (bank_open[sdram_ba])
					protocol_error("activate to a bank that is already open");
				bank_open[sdram_ba] = 1'b1;
				open_row[sdram_ba]  = sdram_adr;
				act_cyc[sdram_ba]   = cyc;
			end
			ddram_cmd_pkg::CMD_READ, ddram_cmd_pkg::CMD_WRITE: begin
				if (!sdram_cke)
					protocol_error("read or write while the clock enable is low");
				if (!bank_open[sdram_ba])
					protocol_error("read or write to a closed row");
				else if (cyc - act_cyc[sdram_ba] < ddram_cmd_pkg::T_RCD)
					protocol_error("read or write issued before T_RCD");
				wr_key = {sdram_ba, open_row[sdram_ba], sdram_adr[8:0]};
				if (pcmd == ddram_cmd_pkg::CMD_WRITE) begin
					store(wr_key, sdram_dq, sdram_dqm);
					wr_beat = 1'b1;
				end else begin
					rd_key  = wr_key;
					rd_step = 1;
				end
			end
			ddram_cmd_pkg::CMD_PRE: begin
				if (sdram_adr[10])
					bank_open = '0;
				else
					bank_open[sdram_ba] = 1'b0;
			end
			ddram_cmd_pkg::CMD_REF: begin
				ref_count++;
				if (bank_open != '0)
					protocol_error("refresh while a bank is open");
			end
			default: ;
		endcase
	end
end

endmodule
